//--- ooo_core.f
logic/ooo_pkg.sv
logic/fetch_unit.sv
logic/dispatch_unit.sv
logic/reservation_station.sv
logic/exec_unit.sv
logic/cdb_arbiter.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
test/ooo_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, search the output for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f ooo_core.f
out=$(./obj_dir/Vooo_core_tb)
echo "$out"
if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

//--- test/ooo_core_tb.sv
// testbench for the core: clock, reset, wishbone instruction memory, reference model, tests
`timescale 1ns/1ns

module ooo_core_tb;
    import ooo_pkg::*;

    // instructions over all tests, sets the run limit
    localparam int instr_total = 87;
    localparam int cycle_limit = 40 * instr_total;
    localparam logic [31:0] nop_word = 32'h00000013;

    logic            clock;
    logic            reset;
    logic            wb_cyc;
    logic            wb_stb;
    logic [xlen-1:0] wb_adr;
    logic            wb_ack;
    logic [xlen-1:0] wb_rdata;
    commit_t         commit;

    // program image and expected commit stream
    logic [31:0] program_words [$];
    int          exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] ref_regs [32];

    string test_name;
    int    errors;
    int    checked;
    int    got_count;
    int    want_count;
    int    cycles;

    ooo_core #(
        .rob_depth(8),
        .rs_entries(2),
        .alu_latency(1),
        .mul_latency(3)
    ) uut (
        .clock, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_rdata, .commit
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////
    // instruction memory
    ////////////////////

    // words past the program read as nop
    function automatic logic [31:0] read_word(input logic [xlen-1:0] adr);
        int index;
        index = int'(adr >> 2);
        if (index < program_words.size()) begin
            return program_words[index];
        end
        return nop_word;
    endfunction

    // ack after 0 to 3 wait cycles and for one cycle
    initial begin : wishbone_memory
        int wait_left;
        wait_left = -1;
        forever begin
            @(posedge clock);
            #2;
            if (wb_stb != wb_cyc) begin
                errors++;
                $display("wb_stb and wb_cyc differ at address %h in %s", wb_adr, test_name);
            end
            if (reset || wb_ack) begin
                wb_ack    = 1'b0;
                wait_left = -1;
            end else if (wb_stb) begin
                if (wait_left < 0) begin
                    wait_left = int'($urandom % 4);
                end
                if (wait_left == 0) begin
                    wb_ack   = 1'b1;
                    wb_rdata = read_word(wb_adr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    ////////////////////
    // reference model
    ////////////////////

    task automatic expect_write(input int rd, input logic [31:0] value);
        // x0 never changes and retires as zero
        if (rd != 0) begin
            ref_regs[rd] = value;
        end
        exp_rd.push_back(rd);
        exp_val.push_back((rd == 0) ? 32'h0 : value);
    endtask

    task automatic emit_addi(input int rd, input int rs1, input int imm);
        logic [31:0] value;
        value = ref_regs[rs1] + 32'(imm);
        program_words.push_back({imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011});
        expect_write(rd, value);
    endtask

    task automatic emit_r(input alu_op_t op, input int rd, input int rs1, input int rs2);
        logic [6:0]  funct7;
        logic [2:0]  funct3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        a      = ref_regs[rs1];
        b      = ref_regs[rs2];
        funct7 = 7'b0000000;
        funct3 = 3'b000;
        value  = a + b;
        case (op)
            op_sub: begin
                funct7 = 7'b0100000;
                value  = a - b;
            end
            op_and: begin
                funct3 = 3'b111;
                value  = a & b;
            end
            op_or: begin
                funct3 = 3'b110;
                value  = a | b;
            end
            op_xor: begin
                funct3 = 3'b100;
                value  = a ^ b;
            end
            op_mul: begin
                // low 32 bits of the product
                funct7 = 7'b0000001;
                value  = a * b;
            end
            default: value = a + b;
        endcase
        program_words.push_back({funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011});
        expect_write(rd, value);
    endtask

    // unsupported word retires like addi x0, x0, 0
    task automatic emit_raw(input logic [31:0] word);
        program_words.push_back(word);
        expect_write(0, 32'h0);
    endtask

    ////////////////////
    // commit checking
    ////////////////////

    always @(negedge clock) begin : commit_check
        int          rd;
        logic [31:0] value;
        if (!reset && commit.valid) begin
            if (exp_rd.size() == 0) begin
                // tail of nops fetched past the program
                if (commit.rd != 0 || commit.value != 32'h0) begin
                    errors++;
                    $display("MISMATCH %s: expected x0 = %h, actual x%0d = %h",
                             test_name, 32'h0, commit.rd, commit.value);
                end
            end else begin
                rd    = exp_rd.pop_front();
                value = exp_val.pop_front();
                checked++;
                got_count++;
                if (commit.rd != reg_idx_t'(rd) || commit.value != value) begin
                    errors++;
                    $display("MISMATCH %s: expected x%0d = %h, actual x%0d = %h",
                             test_name, rd, value, commit.rd, commit.value);
                end
            end
        end
    end

    // run limit counted in clock cycles
    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        errors++;
        $display("timeout in %s: only %0d of %0d expected commits arrived",
                 test_name, got_count, want_count);
        finish_run();
    end

    task automatic finish_run();
        $display("commits checked: %0d, errors: %0d", checked, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    ////////////////////
    // test sequencing
    ////////////////////

    // reset held 8 cycles with bus and commit quiet
    task automatic begin_test(input string name);
        @(posedge clock);
        #2;
        reset     = 1'b1;
        test_name = name;
        program_words.delete();
        exp_rd.delete();
        exp_val.delete();
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            #2;
            if (wb_cyc || commit.valid) begin
                errors++;
                $display("wb_cyc or commit.valid high during reset in %s", name);
            end
        end
    endtask

    // release reset, check the first request, wait for every commit
    task automatic run_program();
        want_count = exp_rd.size();
        got_count  = 0;
        reset      = 1'b0;
        @(negedge clock);
        if (wb_cyc || commit.valid) begin
            errors++;
            $display("wb_cyc or commit.valid high right after reset in %s", test_name);
        end
        do begin
            @(negedge clock);
        end while (!wb_cyc);
        if (wb_adr != '0) begin
            errors++;
            $display("MISMATCH %s: first fetch address expected %h, actual %h",
                     test_name, 32'h0, wb_adr);
        end
        while (got_count < want_count) begin
            @(negedge clock);
        end
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    // independent alu ops, x0 writes and an unknown word
    task automatic test_alu_ops();
        begin_test("alu_ops");
        emit_addi(1, 0, 100);
        emit_addi(2, 0, -7);
        emit_addi(3, 0, 1445);
        emit_addi(4, 0, 60);
        emit_r(op_add, 5, 1, 2);
        emit_r(op_sub, 6, 1, 3);
        emit_r(op_and, 7, 3, 4);
        emit_r(op_or, 8, 3, 4);
        emit_r(op_xor, 9, 3, 4);
        emit_addi(0, 1, 5);
        emit_r(op_add, 0, 1, 2);
        // lui x5, decoded as nop
        emit_raw(32'h123452b7);
        run_program();
    endtask

    // each op reads the result just before it
    task automatic test_chain();
        begin_test("dependent_chain");
        emit_addi(10, 0, 3);
        emit_addi(10, 10, 5);
        emit_r(op_add, 11, 10, 10);
        emit_r(op_sub, 12, 11, 10);
        emit_r(op_xor, 13, 12, 11);
        emit_r(op_and, 14, 13, 12);
        emit_r(op_or, 15, 14, 10);
        emit_r(op_add, 10, 15, 11);
        emit_addi(10, 10, -1);
        emit_r(op_sub, 16, 0, 10);
        run_program();
    endtask

    // slow mul ahead of younger fast alu work
    task automatic test_mul_order();
        begin_test("mul_order");
        emit_addi(1, 0, 123);
        emit_addi(2, 0, -45);
        emit_r(op_mul, 3, 1, 2);
        emit_addi(4, 0, 1);
        emit_r(op_add, 5, 1, 1);
        emit_r(op_xor, 6, 2, 1);
        emit_r(op_mul, 7, 3, 3);
        emit_r(op_or, 8, 4, 5);
        emit_r(op_add, 9, 7, 4);
        // product overflows to its low half
        emit_r(op_mul, 10, 7, 7);
        run_program();
    endtask

    // mul then a dependent alu op over and over
    task automatic test_mul_stress();
        int d;
        int a;
        int b;
        begin_test("mul_stress");
        for (int r = 1; r < 8; r++) begin
            emit_addi(r, 0, int'($urandom % 4096) - 2048);
        end
        for (int i = 0; i < 24; i++) begin
            d = 1 + int'($urandom % 7);
            a = 1 + int'($urandom % 7);
            b = 1 + int'($urandom % 7);
            emit_r(op_mul, d, a, b);
            a = 1 + int'($urandom % 7);
            b = 1 + int'($urandom % 7);
            emit_r(alu_op_t'(i % 5), b, d, a);
        end
        run_program();
    endtask

    initial begin : run_tests
        reset     = 1'b1;
        wb_ack    = 1'b0;
        wb_rdata  = '0;
        errors    = 0;
        checked   = 0;
        got_count = 0;
        cycles    = 0;
        test_name = "startup";
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 32'h0;
        end
        void'($urandom(70174));
        test_alu_ops();
        test_chain();
        test_mul_order();
        test_mul_stress();
        finish_run();
    end

endmodule

//--- logic/ooo_core.sv
// top level of the out-of-order core, fetch through commit
`timescale 1ns/1ns

module ooo_core #(
    parameter int rob_depth   = 8,
    parameter int rs_entries  = 2,
    parameter int alu_latency = 1,
    parameter int mul_latency = 3
) (
    input  logic                     clock,
    input  logic                     reset,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [ooo_pkg::xlen-1:0] wb_adr,
    input  logic                     wb_ack,
    input  logic [ooo_pkg::xlen-1:0] wb_rdata,
    output ooo_pkg::commit_t         commit
);
    import ooo_pkg::*;

    // fetch to dispatch
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        instr_ready;
    // dispatch to stations and rob
    issue_t      dispatch_issue;
    logic        alu_push;
    logic        mul_push;
    logic        alu_full;
    logic        mul_full;
    logic        rob_alloc;
    reg_idx_t    rob_alloc_rd;
    rob_tag_t    rob_tail_tag;
    logic        rob_full;
    rob_tag_t    read_tag_a;
    rob_tag_t    read_tag_b;
    operand_t    read_a;
    operand_t    read_b;
    // stations to lanes
    issue_t      alu_exec_issue;
    issue_t      mul_exec_issue;
    logic        alu_issue_valid;
    logic        mul_issue_valid;
    logic        alu_accept;
    logic        mul_accept;
    // lanes to bus
    cdb_t        alu_result;
    cdb_t        mul_result;
    logic        alu_grant;
    logic        mul_grant;
    cdb_t        cdb;

    fetch_unit fetch (
        .clock, .reset, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .wb_rdata,
        .instr_valid, .instr_word, .instr_ready
    );

    dispatch_unit dispatch (
        .clock, .reset, .instr_valid, .instr_word, .instr_ready,
        .rob_full, .rob_tail_tag, .rob_alloc, .rob_alloc_rd,
        .read_tag_a, .read_tag_b, .read_a, .read_b,
        .alu_full, .mul_full, .alu_push, .mul_push,
        .issue(dispatch_issue), .cdb, .commit
    );

    ////////////////////
    // alu lane
    ////////////////////

    reservation_station #(.entries(rs_entries)) alu_station (
        .clock, .reset, .push(alu_push), .issue_in(dispatch_issue), .full(alu_full),
        .cdb, .issue(alu_exec_issue), .issue_valid(alu_issue_valid), .accept(alu_accept)
    );

    exec_unit #(.latency(alu_latency)) alu_lane (
        .clock, .reset, .issue(alu_exec_issue), .issue_valid(alu_issue_valid),
        .accept(alu_accept), .result(alu_result), .grant(alu_grant)
    );

    ////////////////////
    // multiplier lane
    ////////////////////

    reservation_station #(.entries(rs_entries)) mul_station (
        .clock, .reset, .push(mul_push), .issue_in(dispatch_issue), .full(mul_full),
        .cdb, .issue(mul_exec_issue), .issue_valid(mul_issue_valid), .accept(mul_accept)
    );

    exec_unit #(.latency(mul_latency)) mul_lane (
        .clock, .reset, .issue(mul_exec_issue), .issue_valid(mul_issue_valid),
        .accept(mul_accept), .result(mul_result), .grant(mul_grant)
    );

    cdb_arbiter arbiter (
        .mul_result, .alu_result, .mul_grant, .alu_grant, .cdb
    );

    reorder_buffer #(.depth(rob_depth)) rob (
        .clock, .reset, .alloc(rob_alloc), .alloc_rd(rob_alloc_rd),
        .tail_tag(rob_tail_tag), .full(rob_full),
        .read_tag_a, .read_tag_b, .read_a, .read_b, .cdb, .commit
    );

endmodule

//--- logic/reorder_buffer.sv
// circular reorder buffer with operand read ports and in-order commit
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int depth = 8
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               alloc,
    input  ooo_pkg::reg_idx_t  alloc_rd,
    output ooo_pkg::rob_tag_t  tail_tag,
    output logic               full,
    input  ooo_pkg::rob_tag_t  read_tag_a,
    input  ooo_pkg::rob_tag_t  read_tag_b,
    output ooo_pkg::operand_t  read_a,
    output ooo_pkg::operand_t  read_b,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::commit_t   commit
);
    import ooo_pkg::*;

    // storage covers the whole tag space, depth limits occupancy
    localparam int slots = 2 ** rob_tag_bits;
    typedef logic [rob_tag_bits:0] count_t;
    localparam count_t depth_count = count_t'(depth);

    reg_idx_t        entry_rd [slots];
    logic [xlen-1:0] entry_value [slots];
    logic [slots-1:0] entry_done;
    rob_tag_t        head;
    rob_tag_t        tail;
    count_t          count;
    logic            retire;

    assign tail_tag = tail;
    assign full     = (count == depth_count);

    // head leaves once its result is in
    assign retire = (count != '0) && entry_done[head];

    // done stays set after retire, so a just-committed tag still reads back
    assign read_a = '{ready: entry_done[read_tag_a], tag: read_tag_a,
                      value: entry_value[read_tag_a]};
    assign read_b = '{ready: entry_done[read_tag_b], tag: read_tag_b,
                      value: entry_value[read_tag_b]};

    ////////////////////
    // pointers and commit
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            entry_done   <= '0;
            commit.valid <= 1'b0;
        end else begin
            if (alloc) begin
                entry_done[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            if (cdb.valid) begin
                entry_done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count        <= count + count_t'(alloc) - count_t'(retire);
            commit.valid <= retire;
            commit.rd    <= entry_rd[head];
            // x0 always retires as zero
            commit.value <= (entry_rd[head] == '0) ? '0 : entry_value[head];
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_rd[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            entry_value[cdb.tag] <= cdb.value;
        end
    end

    // dispatch holds the word while the buffer is full
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        alloc |-> !full);

endmodule

//--- logic/cdb_arbiter.sv
// fixed-priority common data bus arbiter, multiplier first
`timescale 1ns/1ns

module cdb_arbiter (
    input  ooo_pkg::cdb_t mul_result,
    input  ooo_pkg::cdb_t alu_result,
    output logic          mul_grant,
    output logic          alu_grant,
    output ooo_pkg::cdb_t cdb
);

    always_comb begin
        // the longer lane holds more work behind it
        mul_grant = mul_result.valid;
        alu_grant = alu_result.valid && !mul_result.valid;
        if (mul_grant) begin
            cdb = mul_result;
        end else begin
            // idle alu result carries valid low
            cdb = alu_result;
        end
    end

endmodule

//--- logic/exec_unit.sv
// integer execution lane with a pipelined result and stall on lost bus arbitration
`timescale 1ns/1ns

module exec_unit #(
    parameter int latency = 1
) (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    input  logic            issue_valid,
    output logic            accept,
    output ooo_pkg::cdb_t   result,
    input  logic            grant
);
    import ooo_pkg::*;

    logic [latency-1:0] stage_valid;
    rob_tag_t           stage_tag [latency];
    logic [xlen-1:0]    stage_value [latency];
    logic [xlen-1:0]    a;
    logic [xlen-1:0]    b;
    logic [xlen-1:0]    value;
    logic               stall;

    always_comb begin
        a = issue.src_a.value;
        b = issue.src_b.value;
        case (issue.op)
            op_sub:  value = a - b;
            op_and:  value = a & b;
            op_or:   value = a | b;
            op_xor:  value = a ^ b;
            // low half of the product
            op_mul:  value = a * b;
            default: value = a + b;
        endcase
    end

    // whole pipe freezes while the last stage waits for the bus
    assign stall  = stage_valid[latency-1] && !grant;
    assign accept = !stall;
    assign result = '{valid: stage_valid[latency-1], tag: stage_tag[latency-1],
                      value: stage_value[latency-1]};

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= issue_valid;
            for (int i = 1; i < latency; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            stage_tag[0]   <= issue.dest;
            stage_value[0] <= value;
            for (int i = 1; i < latency; i++) begin
                stage_tag[i]   <= stage_tag[i-1];
                stage_value[i] <= stage_value[i-1];
            end
        end
    end

endmodule

//--- logic/reservation_station.sv
// operand-waiting station entries with result bus snoop and oldest-slot issue
`timescale 1ns/1ns

module reservation_station #(
    parameter int entries = 2
) (
    input  logic            clock,
    input  logic            reset,
    input  logic            push,
    input  ooo_pkg::issue_t issue_in,
    output logic            full,
    input  ooo_pkg::cdb_t   cdb,
    output ooo_pkg::issue_t issue,
    output logic            issue_valid,
    input  logic            accept
);
    import ooo_pkg::*;

    localparam int sel_bits = (entries > 1) ? $clog2(entries) : 1;
    typedef logic [sel_bits-1:0] sel_t;

    issue_t             slot [entries];
    logic [entries-1:0] busy;
    sel_t               issue_sel;
    sel_t               push_sel;

    // lowest ready slot goes out, lowest free slot takes the push
    always_comb begin
        issue_valid = 1'b0;
        issue_sel   = '0;
        push_sel    = '0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (busy[i] && slot[i].src_a.ready && slot[i].src_b.ready) begin
                issue_valid = 1'b1;
                issue_sel   = sel_t'(i);
            end
            if (!busy[i]) begin
                push_sel = sel_t'(i);
            end
        end
    end

    assign full  = &busy;
    assign issue = slot[issue_sel];

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            // freed once the exec unit takes it
            if (issue_valid && accept) begin
                busy[issue_sel] <= 1'b0;
            end
            if (push) begin
                busy[push_sel] <= 1'b1;
            end
        end
    end

    ////////////////////
    // operand capture
    ////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < entries; i++) begin
            if (busy[i] && cdb.valid && !slot[i].src_a.ready && slot[i].src_a.tag == cdb.tag) begin
                slot[i].src_a.ready <= 1'b1;
                slot[i].src_a.value <= cdb.value;
            end
            if (busy[i] && cdb.valid && !slot[i].src_b.ready && slot[i].src_b.tag == cdb.tag) begin
                slot[i].src_b.ready <= 1'b1;
                slot[i].src_b.value <= cdb.value;
            end
        end
        // push lands in a slot that was free, no clash with the snoop
        if (push) begin
            slot[push_sel] <= issue_in;
        end
    end

    // dispatch checks the full flag before it pushes
    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        push |-> !full);

endmodule

//--- logic/dispatch_unit.sv
// decoder, rename table, register file, operand lookup and dispatch stall
`timescale 1ns/1ns

module dispatch_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               instr_valid,
    input  logic [31:0]        instr_word,
    output logic               instr_ready,
    input  logic               rob_full,
    input  ooo_pkg::rob_tag_t  rob_tail_tag,
    output logic               rob_alloc,
    output ooo_pkg::reg_idx_t  rob_alloc_rd,
    output ooo_pkg::rob_tag_t  read_tag_a,
    output ooo_pkg::rob_tag_t  read_tag_b,
    input  ooo_pkg::operand_t  read_a,
    input  ooo_pkg::operand_t  read_b,
    input  logic               alu_full,
    input  logic               mul_full,
    output logic               alu_push,
    output logic               mul_push,
    output ooo_pkg::issue_t    issue,
    input  ooo_pkg::cdb_t      cdb,
    input  ooo_pkg::commit_t   commit
);
    import ooo_pkg::*;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;
    localparam logic [6:0] funct7_mul  = 7'b0000001;

    alu_op_t         op;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic            use_imm;
    logic            r_type;
    logic            is_mul;
    logic            fire;
    logic [xlen-1:0] imm;
    operand_t        src_a;
    operand_t        src_b;
    // architectural state and rename map
    logic [xlen-1:0] regfile [32];
    logic [31:0]     rename_valid;
    rob_tag_t        rename_tag [32];
    // tag of the instruction that commits next
    rob_tag_t        commit_tag;

    // register file, then rob value, then the bus, else wait on the tag
    function automatic operand_t lookup(input reg_idx_t r, input logic renamed,
                                        input rob_tag_t tag, input logic [xlen-1:0] rf_value,
                                        input operand_t rob_entry, input cdb_t bus);
        operand_t res;
        res.ready = 1'b1;
        res.tag   = tag;
        res.value = rf_value;
        if (r == '0) begin
            res.value = '0;
        end else if (renamed) begin
            if (rob_entry.ready) begin
                res.value = rob_entry.value;
            end else if (bus.valid && bus.tag == tag) begin
                res.value = bus.value;
            end else begin
                res.ready = 1'b0;
            end
        end
        return res;
    endfunction

    ////////////////////
    // decode
    ////////////////////

    always_comb begin
        op      = op_add;
        rd      = '0;
        rs1     = '0;
        rs2     = '0;
        use_imm = 1'b1;
        imm     = '0;
        r_type  = 1'b0;
        if (instr_word[6:0] == opcode_op) begin
            r_type = 1'b1;
            case ({instr_word[31:25], instr_word[14:12]})
                {funct7_base, 3'b000}: op = op_add;
                {funct7_alt, 3'b000}:  op = op_sub;
                {funct7_base, 3'b111}: op = op_and;
                {funct7_base, 3'b110}: op = op_or;
                {funct7_base, 3'b100}: op = op_xor;
                {funct7_mul, 3'b000}:  op = op_mul;
                default:               r_type = 1'b0;
            endcase
        end
        if (r_type) begin
            rd      = instr_word[11:7];
            rs1     = instr_word[19:15];
            rs2     = instr_word[24:20];
            use_imm = 1'b0;
        end else if (instr_word[6:0] == opcode_op_imm && instr_word[14:12] == 3'b000) begin
            // addi, sign-extended immediate
            rd  = instr_word[11:7];
            rs1 = instr_word[19:15];
            imm = {{20{instr_word[31]}}, instr_word[31:20]};
        end
        // anything else stays addi x0, x0, 0
    end

    ////////////////////
    // operands and stall
    ////////////////////

    assign read_tag_a = rename_tag[rs1];
    assign read_tag_b = rename_tag[rs2];

    always_comb begin
        src_a = lookup(rs1, rename_valid[rs1], read_tag_a, regfile[rs1], read_a, cdb);
        if (use_imm) begin
            src_b = '{ready: 1'b1, tag: '0, value: imm};
        end else begin
            src_b = lookup(rs2, rename_valid[rs2], read_tag_b, regfile[rs2], read_b, cdb);
        end
    end

    assign is_mul      = (op == op_mul);
    // stall on full rob or on the station this op needs
    assign instr_ready = !rob_full && !(is_mul ? mul_full : alu_full);
    assign fire        = instr_valid && instr_ready;

    assign rob_alloc    = fire;
    assign rob_alloc_rd = rd;
    assign alu_push     = fire && !is_mul;
    assign mul_push     = fire && is_mul;
    assign issue        = '{op: op, src_a: src_a, src_b: src_b, dest: rob_tail_tag};

    ////////////////////
    // rename and retire
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            rename_valid <= '0;
            commit_tag   <= '0;
        end else begin
            if (commit.valid) begin
                commit_tag <= commit_tag + 1'b1;
                // only when no younger writer took the register over
                if (rename_tag[commit.rd] == commit_tag) begin
                    rename_valid[commit.rd] <= 1'b0;
                end
            end
            // new mapping wins over a clear at the same edge
            if (fire && rd != '0) begin
                rename_valid[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fire && rd != '0) begin
            rename_tag[rd] <= rob_tail_tag;
        end
        if (commit.valid && commit.rd != '0) begin
            regfile[commit.rd] <= commit.value;
        end
    end

endmodule

//--- logic/fetch_unit.sv
// wishbone classic read master, program counter and one-word instruction buffer
`timescale 1ns/1ns

module fetch_unit (
    input  logic                     clock,
    input  logic                     reset,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [ooo_pkg::xlen-1:0] wb_adr,
    input  logic                     wb_ack,
    input  logic [ooo_pkg::xlen-1:0] wb_rdata,
    output logic                     instr_valid,
    output logic [31:0]              instr_word,
    input  logic                     instr_ready
);
    import ooo_pkg::*;

    logic            req_active;
    logic [xlen-1:0] pc;
    logic            buf_valid;
    logic [31:0]     buf_word;
    logic            buf_free;

    // buffer empty, or handed to dispatch this cycle
    assign buf_free = !buf_valid || instr_ready;

    // cyc and stb always move together
    assign wb_cyc = req_active;
    assign wb_stb = req_active;
    assign wb_adr = pc;

    assign instr_valid = buf_valid;
    assign instr_word  = buf_word;

    always_ff @(posedge clock) begin
        if (reset) begin
            req_active <= 1'b0;
            pc         <= '0;
            buf_valid  <= 1'b0;
        end else begin
            if (req_active) begin
                // ack closes the cycle, next word is one word on
                if (wb_ack) begin
                    req_active <= 1'b0;
                    pc         <= pc + xlen'(4);
                end
            end else if (buf_free) begin
                req_active <= 1'b1;
            end
            if (req_active && wb_ack) begin
                buf_valid <= 1'b1;
            end else if (instr_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    // returned word, valid one cycle after ack
    always_ff @(posedge clock) begin
        if (req_active && wb_ack) begin
            buf_word <= wb_rdata;
        end
    end

    // request held with a stable address until the slave answers
    adr_hold: assert property (@(posedge clock) disable iff (reset)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

//--- logic/ooo_pkg.sv
// widths, opcodes, operation codes and the packed structs shared by the core
package ooo_pkg;

    // data and address width
    localparam int xlen = 32;

    // tag space of the reorder buffer, wraps naturally
    localparam int rob_tag_bits = 3;

    // rv32 major opcodes handled by the decoder
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op     = 7'b0110011;

    typedef logic [4:0] reg_idx_t;
    typedef logic [rob_tag_bits-1:0] rob_tag_t;

    // operations understood by both execution lanes
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_mul
    } alu_op_t;

    // source operand, either a value or the tag of its producer
    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } operand_t;

    // one instruction on its way to or out of a reservation station
    typedef struct packed {
        alu_op_t  op;
        operand_t src_a;
        operand_t src_b;
        rob_tag_t dest;
    } issue_t;

    // one broadcast on the common data bus
    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_t;

    // one retired instruction
    typedef struct packed {
        logic            valid;
        reg_idx_t        rd;
        logic [xlen-1:0] value;
    } commit_t;

endpackage
